/* design/rob_alloc.sv */
/*
 * Head/tail bookkeeping and tag assignment. Full at 15 or more entries
 * used, so a two-wide dispatch always fits. No flush support.
 */
`timescale 1ns/100ps
`default_nettype none

`include "rob_consts.svh"

module rob_alloc
(
  input  logic                      clock,
  input  logic                      reset,
  input  rob_pkg::dispatch_req_t    dispatch_0,
  input  rob_pkg::dispatch_req_t    dispatch_1,
  input  logic [1:0]                retire_count,
  output rob_pkg::tag_grant_t       tag_0,
  output rob_pkg::tag_grant_t       tag_1,
  output rob_pkg::alloc_write_t     write_0,
  output rob_pkg::alloc_write_t     write_1,
  output logic [`ROB_TAG_BITS-1:0]  head,
  output logic                      rob_full
);

  // one extra bit so a completely full buffer (16) is representable
  localparam logic [`ROB_TAG_BITS:0] FULL_LEVEL = (`ROB_TAG_BITS+1)'(`ROB_ENTRIES - 1);

  logic [`ROB_TAG_BITS-1:0] tail;
  logic [`ROB_TAG_BITS-1:0] tail_plus_one;
  logic [`ROB_TAG_BITS:0]   count;
  logic                     accept_0;
  logic                     accept_1;
  logic [1:0]               accept_count;

  //////////////////////////////
  // full rule and acceptance
  //////////////////////////////

  assign rob_full = (count >= FULL_LEVEL);

  // slot 0 of the accepted set is filled by whichever request shows up
  assign accept_0     = ~rob_full & (dispatch_0.valid | dispatch_1.valid);
  assign accept_1     = ~rob_full & dispatch_0.valid & dispatch_1.valid;
  assign accept_count = {1'b0, accept_0} + {1'b0, accept_1};

  // wraps mod 16 by overflow
  assign tail_plus_one = tail + `ROB_TAG_BITS'(1);

  //////////////////////////////
  // tag grants and entry writes
  //////////////////////////////

  assign tag_0.valid = ~rob_full & dispatch_0.valid;
  assign tag_0.tag   = tail;

  // lone dispatch_1 gets the tail tag
  assign tag_1.valid = ~rob_full & dispatch_1.valid;
  assign tag_1.tag   = dispatch_0.valid ? tail_plus_one : tail;

  assign write_0.valid    = accept_0;
  assign write_0.tag      = tail;
  assign write_0.dest_reg = dispatch_0.valid ? dispatch_0.dest_reg : dispatch_1.dest_reg;

  assign write_1.valid    = accept_1;
  assign write_1.tag      = tail_plus_one;
  assign write_1.dest_reg = dispatch_1.dest_reg;

  //////////////////////////////
  // pointer registers
  //////////////////////////////

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end
    else
    begin
      head  <= head + `ROB_TAG_BITS'(retire_count);
      tail  <= tail + `ROB_TAG_BITS'(accept_count);
      // occupancy up by dispatches, down by retirements
      count <= count + (`ROB_TAG_BITS+1)'(accept_count)
                     - (`ROB_TAG_BITS+1)'(retire_count);
    end
  end

endmodule

`default_nettype wire

/* design/rob_consts.svh */
/*
 * ROB sizing constants. ROB_ENTRIES must stay a power of two equal to
 * 2**ROB_TAG_BITS, because the pointers wrap by plain overflow.
 */
`ifndef ROB_CONSTS_SVH
`define ROB_CONSTS_SVH

//////////////////////////////
// buffer geometry
//////////////////////////////

// number of entries; a tag is the entry index
`define ROB_ENTRIES     16
`define ROB_TAG_BITS    4

//////////////////////////////
// payload widths
//////////////////////////////

`define ROB_VALUE_BITS  64
`define ROB_REG_BITS    5

`endif

/* design/rob_entry_array.sv */
/*
 * Entry storage with dispatch write, CDB capture and bypassed operand reads.
 * CDB tags naming empty or complete entries are dropped; cdb_0 wins ties.
 */
`timescale 1ns/100ps
`default_nettype none

`include "rob_consts.svh"

module rob_entry_array
(
  input  logic                       clock,
  input  logic                       reset,
  input  rob_pkg::alloc_write_t      write_0,
  input  rob_pkg::alloc_write_t      write_1,
  input  rob_pkg::cdb_t              cdb_0,
  input  rob_pkg::cdb_t              cdb_1,
  input  logic [`ROB_TAG_BITS-1:0]   read_tag_0,
  input  logic [`ROB_TAG_BITS-1:0]   read_tag_1,
  input  logic [`ROB_TAG_BITS-1:0]   head,
  input  logic [1:0]                 retire_count,
  output rob_pkg::operand_resp_t     operand_0,
  output rob_pkg::operand_resp_t     operand_1,
  output rob_pkg::entry_state_t      head_state_0,
  output rob_pkg::entry_state_t      head_state_1,
  output rob_pkg::retire_t           head_entry_0,
  output rob_pkg::retire_t           head_entry_1
);

  rob_pkg::entry_state_t      state_q [`ROB_ENTRIES];
  rob_pkg::entry_state_t      state_d [`ROB_ENTRIES];
  logic [`ROB_REG_BITS-1:0]   dest_q  [`ROB_ENTRIES];
  logic [`ROB_REG_BITS-1:0]   dest_d  [`ROB_ENTRIES];
  logic [`ROB_VALUE_BITS-1:0] value_q [`ROB_ENTRIES];
  logic [`ROB_VALUE_BITS-1:0] value_d [`ROB_ENTRIES];
  logic [`ROB_ENTRIES-1:0]    retire_hit;
  logic [`ROB_TAG_BITS-1:0]   head_plus_one;

  assign head_plus_one = head + `ROB_TAG_BITS'(1);

  // entries leaving this cycle
  always_comb
  begin
    retire_hit = '0;
    if (retire_count != 2'd0)
      retire_hit[head] = 1'b1;
    if (retire_count == 2'd2)
      retire_hit[head_plus_one] = 1'b1;
  end

  //////////////////////////////
  // per-entry next state
  //////////////////////////////

  always_comb
  begin
    for (int i = 0; i < `ROB_ENTRIES; i++)
    begin
      state_d[i] = state_q[i];
      dest_d[i]  = dest_q[i];
      value_d[i] = value_q[i];
      // retiring and dispatching entries never overlap
      if (retire_hit[i])
        state_d[i] = rob_pkg::ENTRY_EMPTY;
      else if (write_0.valid && write_0.tag == `ROB_TAG_BITS'(i))
      begin
        state_d[i] = rob_pkg::ENTRY_IN_USE;
        dest_d[i]  = write_0.dest_reg;
        value_d[i] = '0;
      end
      else if (write_1.valid && write_1.tag == `ROB_TAG_BITS'(i))
      begin
        state_d[i] = rob_pkg::ENTRY_IN_USE;
        dest_d[i]  = write_1.dest_reg;
        value_d[i] = '0;
      end
      else if (state_q[i] == rob_pkg::ENTRY_IN_USE)
      begin
        // capture, cdb_0 first
        if (cdb_0.valid && cdb_0.tag == `ROB_TAG_BITS'(i))
        begin
          state_d[i] = rob_pkg::ENTRY_COMPLETE;
          value_d[i] = cdb_0.value;
        end
        else if (cdb_1.valid && cdb_1.tag == `ROB_TAG_BITS'(i))
        begin
          state_d[i] = rob_pkg::ENTRY_COMPLETE;
          value_d[i] = cdb_1.value;
        end
      end
    end
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      for (int i = 0; i < `ROB_ENTRIES; i++)
        state_q[i] <= rob_pkg::ENTRY_EMPTY;
    end
    else
    begin
      for (int i = 0; i < `ROB_ENTRIES; i++)
        state_q[i] <= state_d[i];
    end
  end

  // payload, meaningful only while the entry is in use
  always_ff @(posedge clock)
  begin
    for (int i = 0; i < `ROB_ENTRIES; i++)
    begin
      dest_q[i]  <= dest_d[i];
      value_q[i] <= value_d[i];
    end
  end

  //////////////////////////////
  // operand reads with bypass
  //////////////////////////////

  always_comb
  begin
    operand_0.ready = (state_q[read_tag_0] == rob_pkg::ENTRY_COMPLETE);
    operand_0.value = value_q[read_tag_0];
    operand_1.ready = (state_q[read_tag_1] == rob_pkg::ENTRY_COMPLETE);
    operand_1.value = value_q[read_tag_1];
    // same-cycle broadcast overrides storage, cdb_0 last so it wins
    if (cdb_1.valid && cdb_1.tag == read_tag_0)
      operand_0 = '{ready: 1'b1, value: cdb_1.value};
    if (cdb_0.valid && cdb_0.tag == read_tag_0)
      operand_0 = '{ready: 1'b1, value: cdb_0.value};
    if (cdb_1.valid && cdb_1.tag == read_tag_1)
      operand_1 = '{ready: 1'b1, value: cdb_1.value};
    if (cdb_0.valid && cdb_0.tag == read_tag_1)
      operand_1 = '{ready: 1'b1, value: cdb_0.value};
  end

  // head window for retirement
  assign head_state_0 = state_q[head];
  assign head_state_1 = state_q[head_plus_one];

  assign head_entry_0.valid    = (head_state_0 == rob_pkg::ENTRY_COMPLETE);
  assign head_entry_0.dest_reg = dest_q[head];
  assign head_entry_0.value    = value_q[head];
  assign head_entry_1.valid    = (head_state_1 == rob_pkg::ENTRY_COMPLETE);
  assign head_entry_1.dest_reg = dest_q[head_plus_one];
  assign head_entry_1.value    = value_q[head_plus_one];

endmodule

`default_nettype wire

/* design/rob_pkg.sv */
/*
 * Types shared between the ROB stages.
 * Widths come from rob_consts.svh, which must be on the include path.
 */
`default_nettype none

`include "rob_consts.svh"

package rob_pkg;

  // entry lifecycle, 2'b11 never used
  typedef enum logic [1:0] {
    ENTRY_EMPTY    = 2'b00,
    ENTRY_IN_USE   = 2'b01,
    ENTRY_COMPLETE = 2'b10
  } entry_state_t;

  // one dispatch slot from the front end
  typedef struct packed {
    logic                       valid;
    logic [`ROB_REG_BITS-1:0]   dest_reg;
  } dispatch_req_t;

  // tag handed back to dispatch
  typedef struct packed {
    logic                       valid;
    logic [`ROB_TAG_BITS-1:0]   tag;
  } tag_grant_t;

  // allocation -> entry storage write
  typedef struct packed {
    logic                       valid;
    logic [`ROB_TAG_BITS-1:0]   tag;
    logic [`ROB_REG_BITS-1:0]   dest_reg;
  } alloc_write_t;

  // common data bus broadcast
  typedef struct packed {
    logic                       valid;
    logic [`ROB_TAG_BITS-1:0]   tag;
    logic [`ROB_VALUE_BITS-1:0] value;
  } cdb_t;

  // operand lookup answer to the reservation stations
  typedef struct packed {
    logic                       ready;
    logic [`ROB_VALUE_BITS-1:0] value;
  } operand_resp_t;

  // register write leaving the ROB, also the head-window view
  typedef struct packed {
    logic                       valid;
    logic [`ROB_REG_BITS-1:0]   dest_reg;
    logic [`ROB_VALUE_BITS-1:0] value;
  } retire_t;

endpackage

`default_nettype wire

/* design/rob_retire.sv */
/*
 * In-order two-wide retirement with one registered output stage.
 * head+1 only retires alongside head; retire_count is combinational.
 */
`timescale 1ns/100ps
`default_nettype none

`include "rob_consts.svh"

module rob_retire
(
  input  logic               clock,
  input  logic               reset,
  input  rob_pkg::retire_t   head_entry_0,
  input  rob_pkg::retire_t   head_entry_1,
  output logic [1:0]         retire_count,
  output rob_pkg::retire_t   retire_0,
  output rob_pkg::retire_t   retire_1
);

  logic                       take_0;
  logic                       take_1;
  logic [1:0]                 valid_q;
  logic [`ROB_REG_BITS-1:0]   dest_0_q;
  logic [`ROB_REG_BITS-1:0]   dest_1_q;
  logic [`ROB_VALUE_BITS-1:0] value_0_q;
  logic [`ROB_VALUE_BITS-1:0] value_1_q;

  //////////////////////////////
  // selection
  //////////////////////////////

  // program order: second slot needs the first
  assign take_0 = head_entry_0.valid;
  assign take_1 = head_entry_0.valid & head_entry_1.valid;

  assign retire_count = {1'b0, take_0} + {1'b0, take_1};

  //////////////////////////////
  // output stage
  //////////////////////////////

  always_ff @(posedge clock)
  begin
    if (reset)
      valid_q <= 2'b00;
    else
      valid_q <= {take_1, take_0};
  end

  // payload follows the head window every cycle
  always_ff @(posedge clock)
  begin
    dest_0_q  <= head_entry_0.dest_reg;
    value_0_q <= head_entry_0.value;
    dest_1_q  <= head_entry_1.dest_reg;
    value_1_q <= head_entry_1.value;
  end

  assign retire_0 = '{valid: valid_q[0], dest_reg: dest_0_q, value: value_0_q};
  assign retire_1 = '{valid: valid_q[1], dest_reg: dest_1_q, value: value_1_q};

endmodule

`default_nettype wire

/* design/rob_top.sv */
/*
 * Two-wide reorder buffer. Requesters hold and retry while rob_full is high.
 * No mispredict flush or exception handling.
 */
`timescale 1ns/100ps
`default_nettype none

`include "rob_consts.svh"

module rob_top
(
  input  logic                      clock,
  input  logic                      reset,
  // dispatch
  input  rob_pkg::dispatch_req_t    dispatch_0,
  input  rob_pkg::dispatch_req_t    dispatch_1,
  output rob_pkg::tag_grant_t       tag_0,
  output rob_pkg::tag_grant_t       tag_1,
  output logic                      rob_full,
  // completion
  input  rob_pkg::cdb_t             cdb_0,
  input  rob_pkg::cdb_t             cdb_1,
  // operand read
  input  logic [`ROB_TAG_BITS-1:0]  read_tag_0,
  input  logic [`ROB_TAG_BITS-1:0]  read_tag_1,
  output rob_pkg::operand_resp_t    operand_0,
  output rob_pkg::operand_resp_t    operand_1,
  // retirement
  output rob_pkg::retire_t          retire_0,
  output rob_pkg::retire_t          retire_1
);

  rob_pkg::alloc_write_t     write_0;
  rob_pkg::alloc_write_t     write_1;
  logic [`ROB_TAG_BITS-1:0]  head;
  logic [1:0]                retire_count;
  rob_pkg::retire_t          head_entry_0;
  rob_pkg::retire_t          head_entry_1;

  //////////////////////////////
  // stages
  //////////////////////////////

  rob_alloc u_alloc (
    .clock        (clock),
    .reset        (reset),
    .dispatch_0   (dispatch_0),
    .dispatch_1   (dispatch_1),
    .retire_count (retire_count),
    .tag_0        (tag_0),
    .tag_1        (tag_1),
    .write_0      (write_0),
    .write_1      (write_1),
    .head         (head),
    .rob_full     (rob_full)
  );

  // head states are folded into head_entry valids, not needed here
  rob_entry_array u_entries (
    .clock        (clock),
    .reset        (reset),
    .write_0      (write_0),
    .write_1      (write_1),
    .cdb_0        (cdb_0),
    .cdb_1        (cdb_1),
    .read_tag_0   (read_tag_0),
    .read_tag_1   (read_tag_1),
    .head         (head),
    .retire_count (retire_count),
    .operand_0    (operand_0),
    .operand_1    (operand_1),
    .head_state_0 (),
    .head_state_1 (),
    .head_entry_0 (head_entry_0),
    .head_entry_1 (head_entry_1)
  );

  rob_retire u_retire (
    .clock        (clock),
    .reset        (reset),
    .head_entry_0 (head_entry_0),
    .head_entry_1 (head_entry_1),
    .retire_count (retire_count),
    .retire_0     (retire_0),
    .retire_1     (retire_1)
  );

endmodule

`default_nettype wire

/* files.f */
+incdir+design
design/rob_pkg.sv
design/rob_alloc.sv
design/rob_entry_array.sv
design/rob_retire.sv
design/rob_top.sv
tb/tb_rob.sv

/* run.sh */
#!/usr/bin/env bash
# build the ROB testbench with Verilator, run it, and look for the pass line
set -e

cd "$(dirname "$0")"
rm -rf obj_dir

verilator --binary --timing -Wno-fatal --top-module tb_rob -f files.f --Mdir obj_dir

# the simulation status is not trusted, only the log
./obj_dir/Vtb_rob | tee sim.log

if grep -qx "TESTBENCH PASSED" sim.log
then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

/* tb/tb_rob.sv */
/*
 * Directed testbench for the two-wide ROB. Inputs change at the rising edge,
 * outputs are sampled at the falling edge. Stops at the first error.
 */
`timescale 1ns/100ps
`default_nettype none

`include "rob_consts.svh"

module tb_rob;

  // tests need under 400 cycles
  localparam int MAX_CYCLES = 2000;

  logic                     clock;
  logic                     reset;
  rob_pkg::dispatch_req_t   dispatch_0;
  rob_pkg::dispatch_req_t   dispatch_1;
  rob_pkg::tag_grant_t      tag_0;
  rob_pkg::tag_grant_t      tag_1;
  logic                     rob_full;
  rob_pkg::cdb_t            cdb_0;
  rob_pkg::cdb_t            cdb_1;
  logic [`ROB_TAG_BITS-1:0] read_tag_0;
  logic [`ROB_TAG_BITS-1:0] read_tag_1;
  rob_pkg::operand_resp_t   operand_0;
  rob_pkg::operand_resp_t   operand_1;
  rob_pkg::retire_t         retire_0;
  rob_pkg::retire_t         retire_1;
  int                       cycles = 0;

  // reference model indexed by tag
  logic [`ROB_REG_BITS-1:0]   model_reg  [`ROB_ENTRIES];
  logic [`ROB_VALUE_BITS-1:0] model_val  [`ROB_ENTRIES];
  logic                       model_busy [`ROB_ENTRIES];
  logic                       model_done [`ROB_ENTRIES];
  logic [`ROB_TAG_BITS-1:0]   model_head;
  logic [`ROB_TAG_BITS-1:0]   model_tail;
  int                         model_count;

  rob_top DUT (.*);

  always #50 clock = ~clock;

  always @(posedge clock)
  begin
    if (cycles == MAX_CYCLES)
    begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      stop_on_failure();
    end
    else
      cycles <= cycles + 1;
  end

  //////////////////////////////
  // checking helpers
  //////////////////////////////

  task automatic stop_on_failure;
    $display("TESTBENCH FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_equal(input string name, input logic [69:0] actual,
                             input logic [69:0] expected);
    if (actual !== expected)
    begin
      $display("mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      stop_on_failure();
    end
  endtask

  function automatic logic [63:0] random_value();
    return {$urandom(), $urandom()};
  endfunction

  // every retire must match the oldest entry in the model
  task automatic retire_one(input rob_pkg::retire_t r);
    if (model_count == 0 || !model_done[model_head])
    begin
      $display("entry %0d retired before it was dispatched and completed", model_head);
      stop_on_failure();
    end
    else
    begin
      check_equal("retire.dest_reg", r.dest_reg, model_reg[model_head]);
      check_equal("retire.value", r.value, model_val[model_head]);
      model_busy[model_head] = 1'b0;
      model_done[model_head] = 1'b0;
      model_head = model_head + 4'd1;
      model_count = model_count - 1;
    end
  endtask

  always @(negedge clock)
  begin
    if (!reset)
    begin
      if (retire_1.valid && !retire_0.valid)
      begin
        $display("retire_1 was valid while retire_0 was not");
        stop_on_failure();
      end
      else
      begin
        if (retire_0.valid)
          retire_one(retire_0);
        if (retire_1.valid)
          retire_one(retire_1);
      end
    end
  end

  //////////////////////////////
  // stimulus tasks
  //////////////////////////////

  // one dispatch cycle with tags from the model tail
  task automatic dispatch_pair(input logic v0, input logic [4:0] r0, input logic v1,
                               input logic [4:0] r1, input logic full);
    logic [3:0] t0;
    logic [3:0] t1;
    @(posedge clock);
    dispatch_0 <= '{valid: v0, dest_reg: r0};
    dispatch_1 <= '{valid: v1, dest_reg: r1};
    @(negedge clock);
    t0 = model_tail;
    t1 = v0 ? model_tail + 4'd1 : model_tail;
    check_equal("rob_full", rob_full, full);
    check_equal("tag_0.valid", tag_0.valid, v0 & ~full);
    check_equal("tag_1.valid", tag_1.valid, v1 & ~full);
    if (v0 && !full)
    begin
      check_equal("tag_0.tag", tag_0.tag, t0);
      model_reg[t0] = r0;
      model_busy[t0] = 1'b1;
      model_tail = t0 + 4'd1;
      model_count = model_count + 1;
    end
    if (v1 && !full)
    begin
      check_equal("tag_1.tag", tag_1.tag, t1);
      model_reg[t1] = r1;
      model_busy[t1] = 1'b1;
      model_tail = t1 + 4'd1;
      model_count = model_count + 1;
    end
    @(posedge clock);
    dispatch_0 <= '0;
    dispatch_1 <= '0;
  endtask

  // one broadcast cycle that also checks the operand bypass
  task automatic broadcast(input logic v0, input logic [3:0] t0, input logic [63:0] x0,
                           input logic v1, input logic [3:0] t1, input logic [63:0] x1);
    logic take_1;
    @(posedge clock);
    cdb_0 <= '{valid: v0, tag: t0, value: x0};
    cdb_1 <= '{valid: v1, tag: t1, value: x1};
    @(negedge clock);
    if (v0 && t0 == read_tag_0)
      check_equal("operand_0", operand_0, {1'b1, x0});
    else if (v1 && t1 == read_tag_0)
      check_equal("operand_0", operand_0, {1'b1, x1});
    if (v0 && t0 == read_tag_1)
      check_equal("operand_1", operand_1, {1'b1, x0});
    else if (v1 && t1 == read_tag_1)
      check_equal("operand_1", operand_1, {1'b1, x1});
    // only in-use entries capture and cdb_0 wins a shared tag
    take_1 = v1 && model_busy[t1] && !model_done[t1] && !(v0 && t0 == t1);
    if (v0 && model_busy[t0] && !model_done[t0])
    begin
      model_done[t0] = 1'b1;
      model_val[t0] = x0;
    end
    if (take_1)
    begin
      model_done[t1] = 1'b1;
      model_val[t1] = x1;
    end
    @(posedge clock);
    cdb_0 <= '0;
    cdb_1 <= '0;
  endtask

  // completes every outstanding entry with the younger one on cdb_0
  task automatic complete_outstanding;
    logic [3:0] t;
    int         n;
    t = model_head;
    n = model_count;
    while (n > 0)
    begin
      if (n >= 2)
        broadcast(1'b1, t + 4'd1, random_value(), 1'b1, t, random_value());
      else
        broadcast(1'b1, t, random_value(), 1'b0, 4'd0, 64'd0);
      t = t + 4'd2;
      n = n - 2;
    end
  endtask

  task automatic wait_drained;
    while (model_count != 0)
      @(negedge clock);
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////

  task automatic reset_outputs_idle;
    @(negedge clock);
    check_equal("retire_0.valid", retire_0.valid, 1'b0);
    check_equal("retire_1.valid", retire_1.valid, 1'b0);
    check_equal("tag_0.valid", tag_0.valid, 1'b0);
    check_equal("tag_1.valid", tag_1.valid, 1'b0);
    check_equal("rob_full", rob_full, 1'b0);
  endtask

  task automatic dispatch_tag_order;
    dispatch_pair(1'b1, 5'd1, 1'b1, 5'd2, 1'b0);
    dispatch_pair(1'b1, 5'd3, 1'b0, 5'd0, 1'b0);
    // lone dispatch_1 takes the tail tag
    dispatch_pair(1'b0, 5'd0, 1'b1, 5'd4, 1'b0);
    dispatch_pair(1'b1, 5'd5, 1'b1, 5'd6, 1'b0);
    complete_outstanding();
    wait_drained();
  endtask

  task automatic fill_until_full;
    for (int i = 0; i < 7; i++)
      dispatch_pair(1'b1, 5'(i), 1'b1, 5'(i + 8), 1'b0);
    dispatch_pair(1'b1, 5'd20, 1'b0, 5'd0, 1'b0);
    // 15 in use so requests are refused
    dispatch_pair(1'b1, 5'd21, 1'b1, 5'd22, 1'b1);
    dispatch_pair(1'b0, 5'd0, 1'b1, 5'd23, 1'b1);
    broadcast(1'b1, model_head, random_value(), 1'b0, 4'd0, 64'd0);
    do
      @(negedge clock);
    while (rob_full);
    dispatch_pair(1'b1, 5'd24, 1'b1, 5'd25, 1'b0);
    @(negedge clock);
    check_equal("rob_full", rob_full, 1'b1);
    complete_outstanding();
    wait_drained();
  endtask

  task automatic retire_in_order;
    logic [3:0]  h;
    logic [63:0] x [4];
    h = model_tail;
    for (int i = 0; i < 4; i++)
      x[i] = random_value();
    dispatch_pair(1'b1, 5'd7, 1'b1, 5'd8, 1'b0);
    dispatch_pair(1'b1, 5'd9, 1'b1, 5'd10, 1'b0);
    broadcast(1'b1, h + 4'd2, x[2], 1'b1, h + 4'd1, x[1]);
    // nothing may retire while the head is in flight
    repeat (3)
    begin
      @(negedge clock);
      check_equal("retire_0.valid", retire_0.valid, 1'b0);
    end
    broadcast(1'b1, h, x[0], 1'b0, 4'd0, 64'd0);
    @(negedge clock);
    check_equal("retire_0.valid", retire_0.valid, 1'b0);
    @(negedge clock);
    check_equal("retire_0", retire_0, {1'b1, 5'd7, x[0]});
    check_equal("retire_1", retire_1, {1'b1, 5'd8, x[1]});
    @(negedge clock);
    check_equal("retire_0", retire_0, {1'b1, 5'd9, x[2]});
    check_equal("retire_1.valid", retire_1.valid, 1'b0);
    broadcast(1'b1, h + 4'd3, x[3], 1'b0, 4'd0, 64'd0);
    repeat (2)
      @(negedge clock);
    check_equal("retire_0", retire_0, {1'b1, 5'd10, x[3]});
    wait_drained();
  endtask

  task automatic operand_bypass_read;
    logic [3:0] h;
    h = model_tail;
    dispatch_pair(1'b1, 5'd11, 1'b1, 5'd12, 1'b0);
    @(posedge clock);
    read_tag_0 <= h + 4'd1;
    read_tag_1 <= h;
    @(negedge clock);
    check_equal("operand_0.ready", operand_0.ready, 1'b0);
    check_equal("operand_1.ready", operand_1.ready, 1'b0);
    // younger entry completes first and stays behind the head
    broadcast(1'b0, 4'd0, 64'd0, 1'b1, h + 4'd1, random_value());
    repeat (3)
    begin
      @(negedge clock);
      check_equal("operand_0", operand_0, {1'b1, model_val[h + 4'd1]});
      check_equal("operand_1.ready", operand_1.ready, 1'b0);
    end
    broadcast(1'b1, h, random_value(), 1'b0, 4'd0, 64'd0);
    wait_drained();
    @(negedge clock);
    check_equal("operand_0.ready", operand_0.ready, 1'b0);
  endtask

  task automatic stray_cdb_ignored;
    logic [3:0] t;
    t = model_tail;
    @(posedge clock);
    read_tag_0 <= t;
    broadcast(1'b1, t, random_value(), 1'b0, 4'd0, 64'd0);
    @(negedge clock);
    check_equal("operand_0.ready", operand_0.ready, 1'b0);
    dispatch_pair(1'b1, 5'd13, 1'b0, 5'd0, 1'b0);
    @(negedge clock);
    check_equal("operand_0.ready", operand_0.ready, 1'b0);
    // retire must carry this value and not the stray one
    broadcast(1'b0, 4'd0, 64'd0, 1'b1, t, random_value());
    repeat (2)
      @(negedge clock);
    check_equal("retire_0", retire_0, {1'b1, 5'd13, model_val[t]});
    wait_drained();
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial
  begin
    void'($urandom(32'h88d4_a8ef));
    for (int i = 0; i < `ROB_ENTRIES; i++)
    begin
      model_busy[i] = 1'b0;
      model_done[i] = 1'b0;
    end
    model_head  = '0;
    model_tail  = '0;
    model_count = 0;
    clock       = 1'b0;
    reset       = 1'b1;
    dispatch_0  = '0;
    dispatch_1  = '0;
    cdb_0       = '0;
    cdb_1       = '0;
    read_tag_0  = '0;
    read_tag_1  = '0;
    repeat (2)
      @(posedge clock);
    reset <= 1'b0;
    reset_outputs_idle();
    dispatch_tag_order();
    fill_until_full();
    retire_in_order();
    operand_bypass_read();
    stray_cdb_ignored();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire
